// File: data_mem.f
verilog/mem_pkg.sv
verilog/sp_ram.sv
verilog/sp_ram_be.sv
verilog/store_align.sv
verilog/load_extract.sv
verilog/data_mem.sv
testbench/data_mem_chk.sv
testbench/data_mem_tb.sv

// File: testbench/data_mem_chk.sv
//**********************************************************
// Protocol assertions on the data memory ports
//**********************************************************

`timescale 1ns/1ps

module data_mem_chk (
   input logic              clk,
   input logic              rst_n,
   input logic              req,
   input logic              rsp_valid,
   input mem_pkg::mem_rsp_t rsp_data
);

   // One answer per request exactly one cycle later
   a_req_rsp: assert property (@(posedge clk) disable iff (!rst_n)
      req |=> rsp_valid)
      else $error("Request without a response one cycle later");

   a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid |-> $past(req))
      else $error("Response without a request in the cycle before");

   a_err_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (rsp_valid && rsp_data.err) |-> (rsp_data.rdata == 32'd0))
      else $error("Error response with nonzero read data");

   a_reset_idle: assert property (@(posedge clk)
      !rst_n |=> !rsp_valid)
      else $error("Response strobe high during reset");

endmodule

bind data_mem data_mem_chk u_chk (
   .clk       (clk),
   .rst_n     (rst_n),
   .req       (req),
   .rsp_valid (rsp_valid),
   .rsp_data  (rsp_data)
);

// File: testbench/data_mem_input.txt
# name op addr wdata exp_rdata exp_err (hex fields)
# op: 0 lb, 1 lbu, 2 lh, 3 lhu, 4 lw, 5 sb, 6 sh, 7 sw
sw_word 7 00000010 12345678 00000000 0
lw_word 4 00000010 00000000 12345678 0
sw_fill 7 00000020 aaaaaaaa 00000000 0
sb_off0 5 00000020 ffffff11 00000000 0
lw_after_sb0 4 00000020 00000000 aaaaaa11 0
sb_off1 5 00000021 12345622 00000000 0
sb_off2 5 00000022 00000033 00000000 0
sb_off3 5 00000023 abcdef44 00000000 0
lw_bytes 4 00000020 00000000 44332211 0
sw_signs 7 00000030 c3a58e7f 00000000 0
lb_off0 0 00000030 00000000 0000007f 0
lb_off1 0 00000031 00000000 ffffff8e 0
lbu_off1 1 00000031 00000000 0000008e 0
lb_off3 0 00000033 00000000 ffffffc3 0
lbu_off3 1 00000033 00000000 000000c3 0
lh_off0 2 00000030 00000000 ffff8e7f 0
lhu_off0 3 00000030 00000000 00008e7f 0
lh_off2 2 00000032 00000000 ffffc3a5 0
lhu_off2 3 00000032 00000000 0000c3a5 0
sh_misaligned 6 00000031 0000beef 00000000 1
sw_misaligned 7 00000032 deadbeef 00000000 1
lh_misaligned 2 00000033 00000000 00000000 1
lw_misaligned 4 00000031 00000000 00000000 1
lw_unchanged 4 00000030 00000000 c3a58e7f 0
sw_alias_high 7 00001040 5a5a0f0f 00000000 0
lw_alias_low 4 00000040 00000000 5a5a0f0f 0
sw_low 7 00000050 01020304 00000000 0
lw_alias_top 4 fffff050 00000000 01020304 0

// File: testbench/data_mem_tb.sv
//**********************************************************
// Data memory testbench with file-driven accesses and response checks
//**********************************************************

`timescale 1ns/1ps

module data_mem_tb;

   localparam int max_vec = 64;

   logic              clk;
   logic              rst_n;
   logic              req;
   mem_pkg::mem_req_t req_data;
   logic              rsp_valid;
   mem_pkg::mem_rsp_t rsp_data;

   // Vectors from the input file
   string       vec_name  [0:max_vec-1];
   logic [2:0]  vec_op    [0:max_vec-1];
   logic [31:0] vec_addr  [0:max_vec-1];
   logic [31:0] vec_wdata [0:max_vec-1];
   logic [31:0] vec_rdata [0:max_vec-1];
   logic        vec_err   [0:max_vec-1];
   int          num_vec;
   logic        loaded;

   data_mem #(
      .addr_width (10)
   ) dut0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .req_data  (req_data),
      .rsp_valid (rsp_valid),
      .rsp_data  (rsp_data)
   );

   always #2 clk = ~clk;   // 4 ns period

   task automatic load_vectors();
      int          fd;
      int          fields;
      string       line;
      string       nm;
      logic [2:0]  op;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [31:0] rdata;
      logic        err;
      fd = $fopen("testbench/data_mem_input.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file testbench/data_mem_input.txt");
         $display("tests failed");
         $fatal(1, "No stimulus");
      end
      num_vec = 0;
      while ($fgets(line, fd) > 0) begin
         if (line.len() > 0 && line.getc(0) != "#") begin
            fields = $sscanf(line, "%s %h %h %h %h %h", nm, op, addr, wdata, rdata, err);
            if (fields == 6 && num_vec < max_vec) begin
               vec_name[num_vec]  = nm;
               vec_op[num_vec]    = op;
               vec_addr[num_vec]  = addr;
               vec_wdata[num_vec] = wdata;
               vec_rdata[num_vec] = rdata;
               vec_err[num_vec]   = err;
               num_vec++;
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic check_rsp(input string name, input mem_pkg::mem_rsp_t exp,
                            input mem_pkg::mem_rsp_t act);
      if (act !== exp) begin
         $display("Fail %s expected rdata %h err %b actual rdata %h err %b",
                  name, exp.rdata, exp.err, act.rdata, act.err);
         $display("tests failed");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic check_valid(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s expected rsp_valid %b actual rsp_valid %b", name, exp, act);
         $display("tests failed");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   // Watchdog allows two cycles per vector plus margin for reset
   initial begin
      wait (loaded);
      repeat (num_vec * 2 + 50) @(posedge clk);
      $display("Responses stopped before all accesses were answered");
      $display("tests failed");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      mem_pkg::mem_rsp_t exp;
      clk        = 1'b0;
      rst_n      = 1'b0;
      req        = 1'b0;
      req_data   = '0;
      loaded     = 1'b0;
      load_vectors();
      loaded = 1'b1;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      exp = '0;
      check_valid("idle_after_reset", 1'b0, rsp_valid);
      check_rsp("idle_after_reset", exp, rsp_data);
      // One request per cycle with the previous answer checked mid-cycle
      for (int i = 0; i <= num_vec; i++) begin
         @(posedge clk);
         if (i < num_vec) begin
            req            <= 1'b1;
            req_data.op    <= mem_pkg::mem_op_e'(vec_op[i]);
            req_data.addr  <= vec_addr[i];
            req_data.wdata <= vec_wdata[i];
         end else begin
            req      <= 1'b0;
            req_data <= '0;
         end
         @(negedge clk);
         if (i > 0) begin
            exp.rdata = vec_rdata[i-1];
            exp.err   = vec_err[i-1];
            check_valid(vec_name[i-1], 1'b1, rsp_valid);
            check_rsp(vec_name[i-1], exp, rsp_data);
         end
      end
      @(negedge clk);
      check_valid("idle_at_end", 1'b0, rsp_valid);
      if (num_vec > 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         $display("tests failed");
         $fatal(1, "No vectors found in the stimulus file");
      end
   end

endmodule

// File: verilog/data_mem.sv
//**********************************************************
// Data memory top with aligner, byte-enable RAM and load extractor
//**********************************************************

`timescale 1ns/1ps

module data_mem #(
   parameter int addr_width = 10   // Word address bits
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              req,
   input  mem_pkg::mem_req_t req_data,
   output logic              rsp_valid,
   output mem_pkg::mem_rsp_t rsp_data
);

   // Aligner to RAM
   logic                        en;
   logic [mem_pkg::num_col-1:0] we;
   logic [addr_width-1:0]       word_addr;
   logic [31:0]                 wdata_lanes;

   // Aligner to extractor
   logic                        load;
   mem_pkg::mem_op_e            op;
   logic [1:0]                  offset;
   logic                        misaligned;

   logic [31:0]                 rword;   // RAM read word

   store_align #(
      .addr_width (addr_width)
   ) u_store_align (
      .req         (req),
      .req_data    (req_data),
      .en          (en),
      .we          (we),
      .word_addr   (word_addr),
      .wdata_lanes (wdata_lanes),
      .load        (load),
      .op          (op),
      .offset      (offset),
      .misaligned  (misaligned)
   );

   sp_ram_be #(
      .addr_width (addr_width)
   ) u_ram (
      .clk  (clk),
      .en   (en),
      .we   (we),
      .addr (word_addr),
      .din  (wdata_lanes),
      .dout (rword)
   );

   load_extract u_load_extract (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .load       (load),
      .op         (op),
      .offset     (offset),
      .misaligned (misaligned),
      .rword      (rword),
      .rsp_valid  (rsp_valid),
      .rsp_data   (rsp_data)
   );

endmodule

// File: verilog/load_extract.sv
//**********************************************************
// Response stage with access shape register and byte/half extract
//**********************************************************

`timescale 1ns/1ps

module load_extract (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              req,
   input  logic              load,
   input  mem_pkg::mem_op_e  op,
   input  logic [1:0]        offset,
   input  logic              misaligned,
   input  logic [31:0]       rword,       // RAM output valid one cycle after en
   output logic              rsp_valid,
   output mem_pkg::mem_rsp_t rsp_data
);

   logic                            valid_q;
   logic                            load_q;
   logic                            err_q;
   mem_pkg::mem_op_e                op_q;
   logic [1:0]                      offset_q;
   logic [mem_pkg::col_width-1:0]   sel_byte;
   logic [15:0]                     sel_half;
   logic [31:0]                     ext;

   // Control bits
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
         load_q  <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         valid_q <= req;
         load_q  <= load;
         err_q   <= req & misaligned;
      end
   end

   // Access shape lined up with rword
   always_ff @(posedge clk) begin
      op_q     <= op;
      offset_q <= offset;
   end

   always_comb begin
      sel_byte = rword[offset_q*mem_pkg::col_width +: mem_pkg::col_width];
      sel_half = offset_q[1] ? rword[31:16] : rword[15:0];
      case (op_q)
         mem_pkg::op_lb:  ext = {{24{sel_byte[7]}}, sel_byte};
         mem_pkg::op_lbu: ext = {24'd0, sel_byte};
         mem_pkg::op_lh:  ext = {{16{sel_half[15]}}, sel_half};
         mem_pkg::op_lhu: ext = {16'd0, sel_half};
         default:         ext = rword;   // lw
      endcase
   end

   assign rsp_valid      = valid_q;
   assign rsp_data.rdata = load_q ? ext : 32'd0;   // Stores and errors answer zero
   assign rsp_data.err   = err_q;

endmodule

// File: verilog/mem_pkg.sv
//**********************************************************
// Lane constants, access opcodes and request/response structs
//**********************************************************

package mem_pkg;

   // Byte lane geometry of one memory word
   localparam int col_width = 8;
   localparam int num_col   = 4;

   // Load/store opcodes
   typedef enum logic [2:0] {
      op_lb  = 3'd0,   // Sign extended byte
      op_lbu = 3'd1,   // Zero extended byte
      op_lh  = 3'd2,   // Sign extended half
      op_lhu = 3'd3,   // Zero extended half
      op_lw  = 3'd4,
      op_sb  = 3'd5,
      op_sh  = 3'd6,
      op_sw  = 3'd7
   } mem_op_e;

   // One access from the load/store unit
   typedef struct packed {
      mem_op_e     op;
      logic [31:0] addr;    // Byte address
      logic [31:0] wdata;   // Store data with low bits used for sb/sh
   } mem_req_t;

   // Answer one cycle after the request
   typedef struct packed {
      logic [31:0] rdata;   // Zero for stores and refused accesses
      logic        err;     // Misaligned access
   } mem_rsp_t;

endpackage

// File: verilog/sp_ram.sv
//**********************************************************
// Single-port read-first RAM for one byte column
//**********************************************************

`timescale 1ns/1ps

module sp_ram #(
   parameter int addr_width = 10
) (
   input  logic                         clk,
   input  logic                         en,
   input  logic                         we,
   input  logic [addr_width-1:0]        addr,
   input  logic [mem_pkg::col_width-1:0] data_in,
   output logic [mem_pkg::col_width-1:0] data_out
);

   // Storage stays undefined until written
   logic [mem_pkg::col_width-1:0] mem [0:(2**addr_width)-1];

   // Old contents come out while the new byte goes in
   always_ff @(posedge clk) begin
      if (en) begin
         data_out <= mem[addr];
         if (we) begin
            mem[addr] <= data_in;
         end
      end
   end

endmodule

// File: verilog/sp_ram_be.sv
//**********************************************************
// Word RAM with byte write enables built from four byte columns
//**********************************************************

`timescale 1ns/1ps

module sp_ram_be #(
   parameter int addr_width = 10
) (
   input  logic                        clk,
   input  logic                        en,
   input  logic [mem_pkg::num_col-1:0] we,    // One strobe per lane
   input  logic [addr_width-1:0]       addr,  // Word address
   input  logic [31:0]                 din,
   output logic [31:0]                 dout
);

   // Each lane is its own column with its own write strobe
   // and all lanes share enable and address
   genvar i;
   generate
      for (i = 0; i < mem_pkg::num_col; i++) begin : g_col
         sp_ram #(
            .addr_width (addr_width)
         ) ram_col (
            .clk      (clk),
            .en       (en),
            .we       (we[i]),
            .addr     (addr),
            .data_in  (din[i*mem_pkg::col_width +: mem_pkg::col_width]),
            .data_out (dout[i*mem_pkg::col_width +: mem_pkg::col_width])
         );
      end
   endgenerate

endmodule

// File: verilog/store_align.sv
//**********************************************************
// Request decode into RAM enable, lane strobes, store data
// and alignment check
//**********************************************************

`timescale 1ns/1ps

module store_align #(
   parameter int addr_width = 10
) (
   input  logic                        req,
   input  mem_pkg::mem_req_t           req_data,
   output logic                        en,
   output logic [mem_pkg::num_col-1:0] we,
   output logic [addr_width-1:0]       word_addr,
   output logic [31:0]                 wdata_lanes,
   output logic                        load,
   output mem_pkg::mem_op_e            op,
   output logic [1:0]                  offset,
   output logic                        misaligned
);

   logic                        is_store;
   logic                        is_byte;
   logic                        is_half;
   logic                        is_word;
   logic [mem_pkg::num_col-1:0] lane_mask;

   // Size and direction from the opcode
   always_comb begin
      is_store = 1'b0;
      is_byte  = 1'b0;
      is_half  = 1'b0;
      is_word  = 1'b0;
      case (req_data.op)
         mem_pkg::op_lb, mem_pkg::op_lbu: is_byte = 1'b1;
         mem_pkg::op_lh, mem_pkg::op_lhu: is_half = 1'b1;
         mem_pkg::op_lw:                  is_word = 1'b1;
         mem_pkg::op_sb: begin
            is_store = 1'b1;
            is_byte  = 1'b1;
         end
         mem_pkg::op_sh: begin
            is_store = 1'b1;
            is_half  = 1'b1;
         end
         mem_pkg::op_sw: begin
            is_store = 1'b1;
            is_word  = 1'b1;
         end
         default: ;
      endcase
   end

   assign offset     = req_data.addr[1:0];
   assign op         = req_data.op;
   assign word_addr  = req_data.addr[addr_width+1:2];   // Upper bits wrap
   assign misaligned = (is_half & offset[0]) | (is_word & (offset != 2'b00));

   // Refused accesses never reach the RAM
   assign en   = req & ~misaligned;
   assign load = en & ~is_store;

   // Lanes covered by the access
   always_comb begin
      lane_mask = '0;
      if (is_byte) begin
         lane_mask[offset] = 1'b1;
      end else if (is_half) begin
         lane_mask[{offset[1], 1'b0} +: 2] = 2'b11;
      end else begin
         lane_mask = '1;
      end
   end

   assign we = (en & is_store) ? lane_mask : '0;

   // Replicate narrow store data so every lane sees it
   always_comb begin
      if (is_byte)
         wdata_lanes = {mem_pkg::num_col{req_data.wdata[mem_pkg::col_width-1:0]}};
      else if (is_half)
         wdata_lanes = {(mem_pkg::num_col/2){req_data.wdata[15:0]}};
      else
         wdata_lanes = req_data.wdata;
   end

endmodule
